/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f --top-module ffe_tb -Mdir obj_dir -o ffe_sim

./obj_dir/ffe_sim | tee sim.log

if grep -q "Simulation finished: PASS" sim.log; then
    exit 0
else
    echo "Simulation reported failure, see sim.log"
    exit 1
fi

/* sim/ffe_clk_gen.sv */
module ffe_clk_gen #(
    parameter int period       = 8,
    parameter int reset_cycles = 10
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // Reset is released on a falling edge, away from the sampling edge.
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

/* sim/ffe_golden.txt */
# T name | W addr data err | R addr mode data err (mode E equal, C capture, G above, L below)
# S code check eq_out | I cycles ; addr and data in hex, code and eq_out in decimal
T readback
R 0c E 00000000 0
W 04 00000004 0
W 08 0000012c 0
W 40 00000100 0
W 44 fffffff0 0
W 48 00000008 0
W 50 00000004 0
W 54 fffffffe 0
W 58 00000001 0
W 5c 00000005 0
R 04 E 00000004 0
R 08 E 0000012c 0
R 44 E fffffff0 0
R 5c E 00000005 0
T errors
R 10 E 00000000 1
W 80 0000007f 1
R 80 E 00000000 0
T load
W 00 00000009 0
R 80 E 00000100 0
R 84 E fffffff0 0
R 9c E 00000005 0
T shifts
W 00 00000000 0
W 00 00000005 0
R 80 E 00000000 0
R 84 E 00000100 0
R 9c E 00000001 0
W 00 00000000 0
W 00 00000007 0
R 80 E 00000100 0
R 9c E 00000000 0
T filter
S 10 1 40
S -20 1 -83
S 30 1 126
S 100 1 390
S 127 1 487
S -128 1 -512
S 100 1 450
T adapt
S 0 0 0
R 0c C 00000000 0
W 00 00000000 0
I 32
R 80 E 00000100 0
R 0c G 00000000 0
R 80 C 00000000 0
S 20 0 0
S 20 0 0
I 32
R 80 G 00000000 0

/* sim/ffe_tb.sv */
module ffe_tb;
    import ffe_pkg::*;

    localparam int    EST_DEPTH = 8;
    localparam string GOLDEN    = "sim/ffe_golden.txt";

    logic        clk;
    logic        rst_n;
    logic [7:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    code_t       adc_code;
    logic        adc_valid;
    sample_t     eq_out;
    logic        eq_valid;

    int          errors      = 0;
    int          checks      = 0;
    int          tests       = 0;
    int          test_errors = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;
    string       test_name   = "";
    logic [31:0] captured;

    ffe_clk_gen #(.period(8), .reset_cycles(10)) u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    ffe_top #(.est_depth(EST_DEPTH)) dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .adc_code  (adc_code),
        .adc_valid (adc_valid),
        .eq_out    (eq_out),
        .eq_valid  (eq_valid)
    );

    // Watchdog.
    always @(posedge clk) begin
        if (rst_n) cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not complete within %0d cycles", cycle_limit);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // ====================
    // Checks
    // ====================

    task automatic record_error();
        errors++;
        test_errors++;
    endtask

    task automatic compare_word(input string what, input logic [31:0] expected,
                                input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            record_error();
            $display("Fail %s: %s expected 0x%08h, actual 0x%08h",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic compare_err(input string what, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            record_error();
            $display("Fail %s: %s expected %b, actual %b", test_name, what, expected, actual);
        end
    endtask

    task automatic compare_sample(input string what, input sample_t expected,
                                  input sample_t actual);
        checks++;
        if (actual !== expected) begin
            record_error();
            $display("Fail %s: %s expected %0d, actual %0d", test_name, what, expected, actual);
        end
    endtask

    // Compares a readback against the value captured earlier.
    task automatic compare_order(input string what, input logic above, input logic [31:0] actual);
        logic ok;
        checks++;
        ok = above ? (int'(actual) > int'(captured)) : (int'(actual) < int'(captured));
        if (!ok) begin
            record_error();
            $display("Fail %s: %s expected %s 0x%08h, actual 0x%08h",
                     test_name, what, above ? "above" : "below", captured, actual);
        end
    endtask

    task automatic close_test();
        if (test_name != "") begin
            tests++;
            if (test_errors == 0) $display("Test %s: passed", test_name);
            else $display("Test %s: %0d errors", test_name, test_errors);
        end
        test_errors = 0;
    endtask

    // ====================
    // Bus drivers
    // ====================

    task automatic apb_transfer(input logic write, input logic [7:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        #2;
        rdata = prdata;
        err   = pslverr;
        compare_err($sformatf("pready at 0x%02h", addr), 1'b1, pready); // No wait states.
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic drive_sample(input code_t code, output logic valid, output sample_t value);
        @(negedge clk);
        adc_code  = code;
        adc_valid = 1'b1;
        @(negedge clk);
        adc_valid = 1'b0;
        valid     = eq_valid;
        value     = eq_out;
    endtask

    // Cycles that the golden file takes, for the watchdog limit.
    task automatic count_cycles(output int total);
        int             fd;
        int             rc;
        int             n;
        logic [7:0]     op;
        string          line;
        total = 0;
        fd = $fopen(GOLDEN, "r");
        if (fd != 0) begin
            while ($fscanf(fd, "%s", op) == 1) begin
                if (op == "I") begin
                    rc = $fscanf(fd, "%d", n);
                    total += n;
                end else begin
                    if (op == "W" || op == "R") total += 3;
                    if (op == "S") total += 2;
                    rc = $fgets(line, fd);
                end
            end
            $fclose(fd);
        end
    endtask

    // ====================
    // Main sequence
    // ====================

    initial begin
        int              fd;
        int              rc;
        int              total;
        int              code_val;
        int              exp_val;
        int              chk;
        int              err_val;
        int              n;
        logic [7:0]      op;
        logic [7:0]      mode;
        logic [8*24-1:0] name;
        logic [7:0]      addr;
        logic [31:0]     data;
        logic [31:0]     rdata;
        logic            err_act;
        logic            valid;
        sample_t         value;
        string           line;

        paddr     = '0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        pwdata    = '0;
        adc_code  = '0;
        adc_valid = 1'b0;
        captured  = '0;

        count_cycles(total);
        cycle_limit = 4 * total;
        fd = $fopen(GOLDEN, "r");
        if (fd == 0) begin
            $display("Cannot open the golden file %s", GOLDEN);
            errors++;
        end else begin
            wait (rst_n === 1'b1);
            while ($fscanf(fd, "%s", op) == 1) begin
                if (op == "#") begin
                    rc = $fgets(line, fd);
                end else if (op == "T") begin
                    rc = $fscanf(fd, "%s", name);
                    close_test();
                    test_name = $sformatf("%0s", name);
                end else if (op == "W") begin
                    rc = $fscanf(fd, "%h %h %d", addr, data, err_val);
                    apb_transfer(1'b1, addr, data, rdata, err_act);
                    compare_err($sformatf("write 0x%02h pslverr", addr), err_val[0], err_act);
                end else if (op == "R") begin
                    rc = $fscanf(fd, "%h %s %h %d", addr, mode, data, err_val);
                    apb_transfer(1'b0, addr, '0, rdata, err_act);
                    compare_err($sformatf("read 0x%02h pslverr", addr), err_val[0], err_act);
                    if (mode == "E") compare_word($sformatf("read 0x%02h", addr), data, rdata);
                    else if (mode == "C") captured = rdata;
                    else compare_order($sformatf("read 0x%02h", addr), mode == "G", rdata);
                end else if (op == "S") begin
                    rc = $fscanf(fd, "%d %d %d", code_val, chk, exp_val);
                    drive_sample(code_t'(code_val), valid, value);
                    if (!valid) begin
                        record_error();
                        $display("Test %s: eq_valid stayed low after the sample with code %0d",
                                 test_name, code_val);
                    end else if (chk != 0) begin
                        compare_sample($sformatf("eq_out for code %0d", code_val),
                                       sample_t'(exp_val), value);
                    end
                end else if (op == "I") begin
                    rc = $fscanf(fd, "%d", n);
                    repeat (n) @(negedge clk);
                end else begin
                    record_error();
                    $display("Unknown operation in the golden file");
                    rc = $fgets(line, fd);
                end
            end
            $fclose(fd);
            close_test();
        end

        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* source/ffe_apb_regs.sv */
module ffe_apb_regs #(
    parameter int est_depth = 8
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [7:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    ffe_ctrl_if.regs    ctrl
);
    import ffe_pkg::*;

    // Tap regions hold 16 words, so est_depth is at most 16.
    localparam int IDX_W = (est_depth > 1) ? $clog2(est_depth) : 1;

    logic             access;
    logic             wr_en;
    logic [IDX_W-1:0] idx;
    logic             idx_ok;
    logic             in_init;
    logic             in_tap;
    logic             addr_err;
    logic             read_only;
    logic [31:0]      rd_data;
    logic [15:0]      pass_count;

    assign access  = psel && penable;
    assign idx     = paddr[IDX_W+1:2];
    assign idx_ok  = int'(paddr[5:2]) < est_depth;
    assign in_init = paddr[7:6] == ADDR_INIT_BASE[7:6];
    assign in_tap  = paddr[7:6] == ADDR_TAP_BASE[7:6];

    // ====================
    // Address decode
    // ====================

    always_comb begin
        rd_data   = '0;
        addr_err  = 1'b0;
        read_only = 1'b0;
        if (paddr[1:0] != 2'b00) begin
            addr_err = 1'b1;
        end else if (in_init) begin
            if (idx_ok) rd_data = 32'(ctrl.ffe_init[idx]); // Sign extended.
            else addr_err = 1'b1;
        end else if (in_tap) begin
            read_only = 1'b1;
            if (idx_ok) rd_data = 32'(ctrl.ffe_est[idx]);
            else addr_err = 1'b1;
        end else begin
            case (paddr)
                ADDR_CTRL:   rd_data = {28'd0, ctrl.inst, ctrl.exec_inst};
                ADDR_GAIN:   rd_data = {28'd0, ctrl.gain};
                ADDR_LEVEL:  rd_data = 32'(ctrl.bit_level);
                ADDR_STATUS: begin
                    rd_data   = {16'd0, pass_count};
                    read_only = 1'b1;
                end
                default:     addr_err = 1'b1;
            endcase
        end
    end

    assign wr_en   = access && pwrite && !addr_err && !read_only;
    assign pready  = 1'b1; // No wait states.
    assign pslverr = access && (addr_err || (pwrite && read_only));
    assign prdata  = (access && !pwrite && !addr_err) ? rd_data : '0;

    // ====================
    // Registers
    // ====================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl.exec_inst <= 1'b0;
            ctrl.inst      <= INST_NOP;
            ctrl.gain      <= '0;
            ctrl.bit_level <= '0;
            for (int k = 0; k < est_depth; k++) begin
                ctrl.ffe_init[k] <= '0;
            end
        end else if (wr_en) begin
            if (in_init) begin
                ctrl.ffe_init[idx] <= tap_t'(pwdata);
            end else begin
                case (paddr)
                    ADDR_CTRL: begin
                        ctrl.exec_inst <= pwdata[0];
                        ctrl.inst      <= ffe_inst_t'(pwdata[3:1]);
                    end
                    ADDR_GAIN:  ctrl.gain      <= gain_t'(pwdata);
                    ADDR_LEVEL: ctrl.bit_level <= sample_t'(pwdata);
                    default: ;
                endcase
            end
        end
    end

    // Wrapping count of completed adaptation passes.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) pass_count <= '0;
        else if (ctrl.pass_done) pass_count <= pass_count + 16'd1;
    end

    a_penable_in_transfer: assert property (
        @(posedge clk) disable iff (!rst_n) penable |-> psel
    );

endmodule

/* source/ffe_ctrl_if.sv */
interface ffe_ctrl_if #(
    parameter int est_depth = 8
);
    import ffe_pkg::*;

    // Software control.
    logic      exec_inst;
    ffe_inst_t inst;
    gain_t     gain;
    sample_t   bit_level;
    tap_t      ffe_init [est_depth];

    // Live taps and adaptation progress.
    tap_t      ffe_est [est_depth];
    logic      pass_done;

    modport regs (output exec_inst, inst, gain, bit_level, ffe_init,
                  input  ffe_est, pass_done);

    modport est  (input  exec_inst, inst, gain, bit_level, ffe_init,
                  output ffe_est, pass_done);

    modport filt (input ffe_est);

endinterface

/* source/ffe_estimator.sv */
module ffe_estimator #(
    parameter int est_depth = 8
) (
    input  logic             clk,
    input  logic             rst_n,
    input  ffe_pkg::sample_t est_bits [est_depth],
    input  ffe_pkg::code_t   current_code,
    ffe_ctrl_if.est          ctrl
);
    import ffe_pkg::*;

    localparam int               POS_W    = (est_depth > 1) ? $clog2(est_depth) : 1;
    localparam logic [POS_W-1:0] LAST_POS = POS_W'(est_depth - 1);

    est_state_t       state;
    est_state_t       next_state;
    logic [POS_W-1:0] tap_pos;
    logic [POS_W-1:0] next_tap_pos;
    tap_acc_t         tap_acc [est_depth];
    tap_acc_t         tap_work;
    tap_acc_t         next_tap_work;
    tap_acc_t         store_val;
    sample_t          cur_sample;
    tap_acc_t         level_ext;
    tap_acc_t         sliced;
    tap_acc_t         err;
    tap_acc_t         adjust;
    logic             store_tap;
    logic             load_init;
    logic             shift_left;
    logic             shift_right;

    // ====================
    // Sign-sliced LMS step
    // ====================

    assign cur_sample = est_bits[tap_pos];
    assign level_ext  = tap_acc_t'(ctrl.bit_level);
    assign sliced     = (cur_sample > 0) ? level_ext : -level_ext;
    assign err        = sliced - tap_acc_t'(cur_sample);
    assign adjust     = (tap_acc_t'(current_code) * err) <<< ctrl.gain;
    assign store_val  = tap_work + adjust; // Second half of the update.

    always_comb begin
        for (int k = 0; k < est_depth; k++) begin
            ctrl.ffe_est[k] = tap_t'(tap_acc[k] >>> FRAC_BITS);
        end
    end

    // ====================
    // FSM
    // ====================

    always_comb begin
        next_state    = state;
        next_tap_pos  = tap_pos;
        next_tap_work = tap_work;
        store_tap     = 1'b0;
        unique case (state)
            IDLE: begin
                next_state   = ctrl.exec_inst ? EXEC : LOAD_CALC;
                next_tap_pos = '0;
            end
            LOAD_CALC: begin
                next_tap_work = tap_acc[tap_pos] + adjust;
                if (ctrl.exec_inst) begin
                    next_state   = EXEC;
                    next_tap_pos = '0;
                end else begin
                    next_state = CALC_STORE;
                end
            end
            CALC_STORE: begin
                store_tap = 1'b1;
                if (ctrl.exec_inst) begin
                    next_state   = EXEC;
                    next_tap_pos = '0;
                end else begin
                    next_state   = LOAD_CALC;
                    next_tap_pos = (tap_pos == LAST_POS) ? '0 : tap_pos + 1'b1;
                end
            end
            EXEC:    next_state = HALT; // Instruction acts here.
            HALT:    next_state = ctrl.exec_inst ? HALT : LOAD_CALC;
            default: next_state = IDLE;
        endcase
    end

    always_comb begin
        load_init   = 1'b0;
        shift_left  = 1'b0;
        shift_right = 1'b0;
        if (state == EXEC) begin
            case (ctrl.inst)
                INST_LOAD_INIT:   load_init   = 1'b1;
                INST_SHIFT_LEFT:  shift_left  = 1'b1;
                INST_SHIFT_RIGHT: shift_right = 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state          <= IDLE;
            tap_pos        <= '0;
            tap_work       <= '0;
            ctrl.pass_done <= 1'b0;
            for (int k = 0; k < est_depth; k++) begin
                tap_acc[k] <= '0;
            end
        end else begin
            state          <= next_state;
            tap_pos        <= next_tap_pos;
            tap_work       <= next_tap_work;
            ctrl.pass_done <= store_tap && (tap_pos == LAST_POS);
            if (load_init) begin
                for (int k = 0; k < est_depth; k++) begin
                    tap_acc[k] <= tap_acc_t'(ctrl.ffe_init[k]) <<< FRAC_BITS;
                end
            end else if (shift_right) begin
                tap_acc[0] <= '0;
                for (int k = 1; k < est_depth; k++) begin
                    tap_acc[k] <= tap_acc[k-1];
                end
            end else if (shift_left) begin
                tap_acc[est_depth-1] <= '0;
                for (int k = 1; k < est_depth; k++) begin
                    tap_acc[k-1] <= tap_acc[k];
                end
            end else if (store_tap) begin
                tap_acc[tap_pos] <= store_val;
            end
        end
    end

    a_state_legal: assert property (
        @(posedge clk) disable iff (!rst_n)
        state inside {IDLE, LOAD_CALC, CALC_STORE, EXEC, HALT}
    );

    a_tap_pos_range: assert property (
        @(posedge clk) disable iff (!rst_n) tap_pos < est_depth
    );

endmodule

/* source/ffe_filter.sv */
module ffe_filter #(
    parameter int est_depth = 8
) (
    input  logic             clk,
    input  logic             rst_n,
    input  ffe_pkg::code_t   adc_code,
    input  logic             adc_valid,
    output ffe_pkg::sample_t eq_out,
    output logic             eq_valid,
    output ffe_pkg::sample_t est_bits [est_depth],
    output ffe_pkg::code_t   current_code,
    ffe_ctrl_if.filt         ctrl
);
    import ffe_pkg::*;

    localparam int SUM_W      = $bits(tap_t) + $bits(code_t) + $clog2(est_depth + 1);
    localparam int SAMPLE_MAX = 2 ** ($bits(sample_t) - 1) - 1;
    localparam int SAMPLE_MIN = -(2 ** ($bits(sample_t) - 1));

    code_t                   codes     [est_depth]; // Element 0 is the newest.
    code_t                   code_next [est_depth];
    logic signed [SUM_W-1:0] fir_sum;
    logic signed [SUM_W-1:0] fir_shifted;
    sample_t                 fir_sat;

    // Delay line as it stands after this edge, so eq_out includes adc_code.
    always_comb begin
        code_next[0] = adc_code;
        for (int k = 1; k < est_depth; k++) begin
            code_next[k] = codes[k-1];
        end
    end

    always_comb begin
        fir_sum = '0;
        for (int k = 0; k < est_depth; k++) begin
            fir_sum = fir_sum + SUM_W'(ctrl.ffe_est[k]) * SUM_W'(code_next[k]);
        end
        fir_shifted = fir_sum >>> FILTER_SHIFT;
        if (fir_shifted > SAMPLE_MAX) fir_sat = sample_t'(SAMPLE_MAX);
        else if (fir_shifted < SAMPLE_MIN) fir_sat = sample_t'(SAMPLE_MIN);
        else fir_sat = sample_t'(fir_shifted);
    end

    // ====================
    // Pipeline registers
    // ====================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            eq_valid <= 1'b0;
            eq_out   <= '0;
            for (int k = 0; k < est_depth; k++) begin
                codes[k]    <= '0;
                est_bits[k] <= '0;
            end
        end else begin
            eq_valid <= adc_valid;
            if (adc_valid) begin
                eq_out      <= fir_sat;
                codes       <= code_next;
                est_bits[0] <= fir_sat; // Window of recent equalized samples.
                for (int k = 1; k < est_depth; k++) begin
                    est_bits[k] <= est_bits[k-1];
                end
            end
        end
    end

    assign current_code = codes[0];

endmodule

/* source/ffe_pkg.sv */
package ffe_pkg;

    // ====================
    // Widths
    // ====================

    localparam int FRAC_BITS    = 14; // Fraction bits of the tap accumulators.
    localparam int FILTER_SHIFT = 6;  // FIR sum scaling before saturation.

    typedef logic signed [7:0]  code_t;   // ADC code.
    typedef logic signed [9:0]  sample_t; // Equalized sample and slice level.
    typedef logic signed [9:0]  tap_t;    // Tap weight as software sees it.
    typedef logic signed [$bits(tap_t)+FRAC_BITS-1:0] tap_acc_t;
    typedef logic        [3:0]  gain_t;   // Left shift of the adaptation step.

    typedef enum logic [2:0] {
        INST_NOP         = 3'd0,
        INST_SHIFT_RIGHT = 3'd2,
        INST_SHIFT_LEFT  = 3'd3,
        INST_LOAD_INIT   = 3'd4
    } ffe_inst_t;

    typedef enum logic [2:0] {
        IDLE,
        LOAD_CALC,
        CALC_STORE,
        EXEC,
        HALT
    } est_state_t;

    // ====================
    // Register map
    // ====================

    localparam logic [7:0] ADDR_CTRL      = 8'h00; // Bit 0 exec, bits 3:1 inst.
    localparam logic [7:0] ADDR_GAIN      = 8'h04;
    localparam logic [7:0] ADDR_LEVEL     = 8'h08;
    localparam logic [7:0] ADDR_STATUS    = 8'h0C; // Pass count.
    localparam logic [7:0] ADDR_INIT_BASE = 8'h40;
    localparam logic [7:0] ADDR_TAP_BASE  = 8'h80;

endpackage

/* source/ffe_top.sv */
module ffe_top #(
    parameter int est_depth = 8
) (
    input  logic             clk,
    input  logic             rst_n,

    // APB slave.
    input  logic [7:0]       paddr,
    input  logic             psel,
    input  logic             penable,
    input  logic             pwrite,
    input  logic [31:0]      pwdata,
    output logic [31:0]      prdata,
    output logic             pready,
    output logic             pslverr,

    // Sample stream.
    input  ffe_pkg::code_t   adc_code,
    input  logic             adc_valid,
    output ffe_pkg::sample_t eq_out,
    output logic             eq_valid
);
    import ffe_pkg::*;

    sample_t est_bits [est_depth];
    code_t   current_code;

    ffe_ctrl_if #(.est_depth(est_depth)) ctrl ();

    ffe_apb_regs #(.est_depth(est_depth)) u_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .ctrl    (ctrl.regs)
    );

    ffe_filter #(.est_depth(est_depth)) u_filter (
        .clk          (clk),
        .rst_n        (rst_n),
        .adc_code     (adc_code),
        .adc_valid    (adc_valid),
        .eq_out       (eq_out),
        .eq_valid     (eq_valid),
        .est_bits     (est_bits),
        .current_code (current_code),
        .ctrl         (ctrl.filt)
    );

    ffe_estimator #(.est_depth(est_depth)) u_estimator (
        .clk          (clk),
        .rst_n        (rst_n),
        .est_bits     (est_bits),
        .current_code (current_code),
        .ctrl         (ctrl.est)
    );

endmodule

/* verilog.f */
source/ffe_pkg.sv
source/ffe_ctrl_if.sv
source/ffe_apb_regs.sv
source/ffe_estimator.sv
source/ffe_filter.sv
source/ffe_top.sv
sim/ffe_clk_gen.sv
sim/ffe_tb.sv
